// File: hw/vdp_bus_pkg.sv
//--------------------------------------------------------------------
// CPU bus definitions for the VDP CPU port
// Data and address widths, video access kinds, CPU FSM states,
// decoded transfer modes and second control byte codes
//--------------------------------------------------------------------

package vdp_bus_pkg;

  // Host and VRAM data byte
  localparam int DATA_W = 8;
  // 16K VRAM address space
  localparam int ADDR_W = 14;

  // Kind of video access in the current slot
  typedef enum logic [1:0]
  {
    AC_NONE    = 2'd0,
    AC_PATTERN = 2'd1,
    AC_SPRITE  = 2'd2,
    AC_CPU     = 2'd3
  } access_t;

  // CPU access FSM
  typedef enum logic [3:0]
  {
    IDLE                = 4'd0,
    RD_MODE0            = 4'd1,
    WR_MODE0            = 4'd2,
    RD_MODE1            = 4'd3,
    WR_MODE1_1ST        = 4'd4,
    WR_MODE1_1ST_IDLE   = 4'd5,
    WR_MODE1_2ND_VREAD  = 4'd6,
    WR_MODE1_2ND_VWRITE = 4'd7,
    WR_MODE1_2ND_RWRITE = 4'd8
  } cpu_state_t;

  // Strobe and mode decode
  typedef enum logic [2:0]
  {
    NONE = 3'd0,
    RD0  = 3'd1,
    WR0  = 3'd2,
    RD1  = 3'd3,
    WR1  = 3'd4
  } xfer_t;

  // Top two bits of the second control byte
  localparam logic [1:0] SECOND_BYTE_RD  = 2'b00;
  localparam logic [1:0] SECOND_BYTE_WR  = 2'b01;
  // Register write, only bit 7 matters
  localparam logic [1:0] SECOND_BYTE_REG = 2'b10;

endpackage

// File: hw/vdp_reg_pkg.sv
//--------------------------------------------------------------------
// Control and status register definitions
// Register indices, mode and enable bit positions, display modes
// and status byte layout
//--------------------------------------------------------------------

package vdp_reg_pkg;

  localparam int NUM_REGS  = 8;
  localparam int REG_IDX_W = 3;

  // Registers with decoded fields
  localparam int REG_MODE0 = 0;
  localparam int REG_MODE1 = 1;
  localparam int REG_NTB   = 2;
  localparam int REG_COLOR = 7;

  // Register 0
  localparam int R0_M3 = 1;

  // Register 1
  localparam int R1_16K   = 7;
  localparam int R1_BLANK = 6;
  localparam int R1_IE    = 5;
  localparam int R1_M1    = 4;
  localparam int R1_M2    = 3;

  // Display modes
  typedef enum logic [1:0]
  {
    OPMODE_GRAPH1 = 2'd0,
    OPMODE_GRAPH2 = 2'd1,
    OPMODE_MULTIC = 2'd2,
    OPMODE_TEXTM  = 2'd3
  } opmode_t;

  // Status byte, fifth sprite number sits below STAT_COLL
  localparam int STAT_INT  = 7;
  localparam int STAT_5TH  = 6;
  localparam int STAT_COLL = 5;

endpackage

// File: hw/vdp_cpu_cmd_if.sv
//--------------------------------------------------------------------
// Command interface from the CPU access FSM to the VRAM port
// and to the register and status block
//--------------------------------------------------------------------

`timescale 1ns/1ps

interface vdp_cpu_cmd_if
  import vdp_bus_pkg::*;
();

  // VRAM side commands
  logic              wrbuf_cpu;
  logic              sched_rd;
  logic              sched_wr;
  logic              load_addr;
  // Register side commands
  logic              write_tmp;
  logic              write_reg;
  logic              destr_rd;
  // Copy of the host data byte
  logic [DATA_W-1:0] cd;

  modport fsm  (output wrbuf_cpu, sched_rd, sched_wr, load_addr,
                       write_tmp, write_reg, destr_rd, cd);
  modport vram (input  wrbuf_cpu, sched_rd, sched_wr, load_addr, cd);
  modport regs (input  write_tmp, write_reg, destr_rd, cd);

endinterface

// File: hw/vdp_access_fsm.sv
//--------------------------------------------------------------------
// CPU access FSM
// Strobe decode, nine-state access sequencer and command issue
//--------------------------------------------------------------------

`timescale 1ns/1ps

module vdp_access_fsm
  import vdp_bus_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              rd_i,
  input  logic              wr_i,
  input  logic              mode_i,
  input  logic [DATA_W-1:0] cd_i,
  vdp_cpu_cmd_if.fsm        cmd,
  output logic              sel_readahead_o
);

  cpu_state_t state_q;
  cpu_state_t state_d;
  xfer_t      xfer;

  // Transfer mode from strobes and mode select
  always_comb
  begin
    xfer = NONE;
    if (rd_i)
      xfer = mode_i ? RD1 : RD0;
    else if (wr_i)
      xfer = mode_i ? WR1 : WR0;
  end

  // State register
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // Data byte passes through to both blocks
  assign cmd.cd = cd_i;

  //--------------------------------------------------------------------
  // Next state and commands
  //--------------------------------------------------------------------
  always_comb
  begin
    state_d         = state_q;
    cmd.wrbuf_cpu   = 1'b0;
    cmd.sched_rd    = 1'b0;
    cmd.sched_wr    = 1'b0;
    cmd.load_addr   = 1'b0;
    cmd.write_tmp   = 1'b0;
    cmd.write_reg   = 1'b0;
    cmd.destr_rd    = 1'b0;
    sel_readahead_o = 1'b0;

    case (state_q)
      // Idle and first-byte-pending states both dispatch new accesses
      IDLE, WR_MODE1_1ST_IDLE:
      begin
        case (xfer)
          RD0: state_d = RD_MODE0;
          WR0: state_d = WR_MODE0;
          RD1: state_d = RD_MODE1;
          WR1:
          begin
            if (state_q == IDLE)
              state_d = WR_MODE1_1ST;
            // Second byte picks the path from its top two bits
            else if (cd_i[7:6] == SECOND_BYTE_RD)
              state_d = WR_MODE1_2ND_VREAD;
            else if (cd_i[7:6] == SECOND_BYTE_WR)
              state_d = WR_MODE1_2ND_VWRITE;
            else if (cd_i[7] == SECOND_BYTE_REG[1])
              state_d = WR_MODE1_2ND_RWRITE;
          end
          default: state_d = state_q;
        endcase
      end

      // Buffer on the bus, next read-ahead once the strobe drops
      RD_MODE0:
      begin
        sel_readahead_o = 1'b1;
        if (xfer == NONE)
        begin
          cmd.sched_rd = 1'b1;
          state_d      = IDLE;
        end
      end

      // Host byte into buffer, write-back after the strobe
      WR_MODE0:
      begin
        cmd.wrbuf_cpu = 1'b1;
        if (xfer == NONE)
        begin
          cmd.sched_wr = 1'b1;
          state_d      = IDLE;
        end
      end

      // Status on the bus, flags cleared at the end
      RD_MODE1:
      begin
        if (xfer == NONE)
        begin
          cmd.destr_rd = 1'b1;
          state_d      = IDLE;
        end
      end

      // First control byte goes to the temporary register
      WR_MODE1_1ST:
      begin
        cmd.write_tmp = 1'b1;
        if (xfer == NONE)
          state_d = WR_MODE1_1ST_IDLE;
      end

      // Address load, then read-ahead from the new address
      WR_MODE1_2ND_VREAD:
      begin
        cmd.load_addr = 1'b1;
        if (xfer == NONE)
        begin
          cmd.sched_rd = 1'b1;
          state_d      = IDLE;
        end
      end

      WR_MODE1_2ND_VWRITE:
      begin
        cmd.load_addr = 1'b1;
        if (xfer == NONE)
          state_d = IDLE;
      end

      WR_MODE1_2ND_RWRITE:
      begin
        cmd.write_reg = 1'b1;
        if (xfer == NONE)
          state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

endmodule

// File: hw/vdp_vram_port.sv
//--------------------------------------------------------------------
// VRAM side of the CPU port
// Auto-increment address, read-ahead/write-back buffer and
// slot-aligned scheduling of VRAM transfers
//--------------------------------------------------------------------

`timescale 1ns/1ps

module vdp_vram_port
  import vdp_bus_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  vdp_cpu_cmd_if.vram       cmd,
  input  logic [DATA_W-1:0] tmp_i,
  input  logic              acc_slot_i,
  input  access_t           access_type_i,
  input  logic [DATA_W-1:0] vram_d_i,
  output logic [ADDR_W-1:0] vram_a_o,
  output logic [DATA_W-1:0] vram_d_o,
  output logic              vram_we_o,
  output logic [DATA_W-1:0] buffer_o
);

  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] buffer_q;
  // Requests wait in sched until a slot, then scan for a CPU slot
  logic              rd_sched_q;
  logic              rd_act_q;
  logic              wr_sched_q;
  logic              wr_act_q;
  logic              cpu_slot;
  logic              rd_done;
  logic              wr_done;

  assign cpu_slot = acc_slot_i && (access_type_i == AC_CPU);
  // A host write in the same cycle wins over the VRAM byte
  assign rd_done  = rd_act_q && cpu_slot && !cmd.wrbuf_cpu;
  assign wr_done  = wr_act_q && cpu_slot;

  // Write strobe for the whole CPU slot phase
  assign vram_we_o = wr_act_q && (access_type_i == AC_CPU);

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      addr_q     <= '0;
      buffer_q   <= '0;
      rd_sched_q <= 1'b0;
      rd_act_q   <= 1'b0;
      wr_sched_q <= 1'b0;
      wr_act_q   <= 1'b0;
    end
    else
    begin
      // Completions first so a same-slot arm survives
      if (rd_done)
      begin
        buffer_q <= vram_d_i;
        rd_act_q <= 1'b0;
      end
      if (wr_done)
        wr_act_q <= 1'b0;

      // Align scheduled requests with the slot phase
      if (rd_sched_q && acc_slot_i)
      begin
        rd_sched_q <= 1'b0;
        rd_act_q   <= 1'b1;
      end
      if (wr_sched_q && acc_slot_i)
      begin
        wr_sched_q <= 1'b0;
        wr_act_q   <= 1'b1;
      end

      if (cmd.sched_wr)
        wr_sched_q <= 1'b1;

      // New read-ahead drops any pending write-back
      if (cmd.sched_rd)
      begin
        wr_sched_q <= 1'b0;
        wr_act_q   <= 1'b0;
        rd_sched_q <= 1'b1;
      end

      // Host write drops any pending read-ahead
      if (cmd.wrbuf_cpu)
      begin
        buffer_q   <= cmd.cd;
        rd_sched_q <= 1'b0;
        rd_act_q   <= 1'b0;
      end

      // Address from second control byte and temporary byte
      if (cmd.load_addr)
        addr_q <= {cmd.cd[ADDR_W-DATA_W-1:0], tmp_i};
      else if (rd_done || wr_done)
        addr_q <= addr_q + 1'b1;
    end
  end

  assign vram_a_o = addr_q;
  assign vram_d_o = buffer_q;
  assign buffer_o = buffer_q;

endmodule

// File: hw/vdp_reg_status.sv
//--------------------------------------------------------------------
// Control registers and status register
// Temporary byte, register file, display mode decode, field decode,
// sticky sprite flags and the interrupt output
//--------------------------------------------------------------------

`timescale 1ns/1ps

module vdp_reg_status
  import vdp_bus_pkg::*;
  import vdp_reg_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  vdp_cpu_cmd_if.regs       cmd,
  input  logic              spr_coll_i,
  input  logic              spr_5th_i,
  input  logic              irq_i,
  input  logic [4:0]        spr_5th_num_i,
  output logic [DATA_W-1:0] tmp_o,
  output logic [DATA_W-1:0] status_o,
  output opmode_t           opmode_o,
  output logic              reg_16k_o,
  output logic              reg_blank_o,
  output logic [3:0]        reg_ntb_o,
  output logic [3:0]        reg_col1_o,
  output logic [3:0]        reg_col0_o,
  output logic              int_n_o
);

  logic [DATA_W-1:0]    tmp_q;
  logic [DATA_W-1:0]    ctrl_q [NUM_REGS];
  logic                 coll_q;
  logic                 fifth_q;
  logic [STAT_COLL-1:0] fifth_num_q;
  logic                 int_q;

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      tmp_q       <= '0;
      ctrl_q      <= '{default: '0};
      coll_q      <= 1'b0;
      fifth_q     <= 1'b0;
      fifth_num_q <= '0;
      int_q       <= 1'b0;
    end
    else
    begin
      // First byte of a control pair
      if (cmd.write_tmp)
        tmp_q <= cmd.cd;
      // Register number in the low bits of the second byte
      if (cmd.write_reg)
        ctrl_q[cmd.cd[REG_IDX_W-1:0]] <= tmp_q;

      // Fifth sprite, number kept from the first event only
      if (spr_5th_i)
      begin
        if (!fifth_q)
          fifth_num_q <= spr_5th_num_i;
        fifth_q <= 1'b1;
      end
      else if (cmd.destr_rd)
        fifth_q <= 1'b0;

      // Collision, set event beats the read clear
      if (spr_coll_i)
        coll_q <= 1'b1;
      else if (cmd.destr_rd)
        coll_q <= 1'b0;

      // Frame interrupt flag
      if (irq_i)
        int_q <= 1'b1;
      else if (cmd.destr_rd)
        int_q <= 1'b0;
    end
  end

  // M1 M2 M3 to display mode, illegal mixes fall back to text
  always_comb
  begin
    case ({ctrl_q[REG_MODE1][R1_M1], ctrl_q[REG_MODE1][R1_M2], ctrl_q[REG_MODE0][R0_M3]})
      3'b000:  opmode_o = OPMODE_GRAPH1;
      3'b001:  opmode_o = OPMODE_GRAPH2;
      3'b010:  opmode_o = OPMODE_MULTIC;
      default: opmode_o = OPMODE_TEXTM;
    endcase
  end

  // Status byte layout
  always_comb
  begin
    status_o                  = '0;
    status_o[STAT_INT]        = int_q;
    status_o[STAT_5TH]        = fifth_q;
    status_o[STAT_COLL]       = coll_q;
    status_o[STAT_COLL-1:0]   = fifth_num_q;
  end

  assign tmp_o       = tmp_q;
  assign reg_16k_o   = ctrl_q[REG_MODE1][R1_16K];
  // BLANK bit set means display enabled
  assign reg_blank_o = ~ctrl_q[REG_MODE1][R1_BLANK];
  assign reg_ntb_o   = ctrl_q[REG_NTB][3:0];
  assign reg_col1_o  = ctrl_q[REG_COLOR][7:4];
  assign reg_col0_o  = ctrl_q[REG_COLOR][3:0];
  // Masked by IE
  assign int_n_o     = ~(int_q & ctrl_q[REG_MODE1][R1_IE]);

endmodule

// File: hw/vdp_cpuio.sv
//--------------------------------------------------------------------
// CPU port top level
// Access FSM, VRAM port, register block and the host read mux
//--------------------------------------------------------------------

`timescale 1ns/1ps

module vdp_cpuio
  import vdp_bus_pkg::*;
  import vdp_reg_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        rd_i,
  input  logic        wr_i,
  input  logic        mode_i,
  input  logic [7:0]  cd_i,
  output logic [7:0]  cd_o,
  input  access_t     access_type_i,
  input  logic        acc_slot_i,
  input  logic [7:0]  vram_d_i,
  output logic [13:0] vram_a_o,
  output logic [7:0]  vram_d_o,
  output logic        vram_we_o,
  input  logic        spr_coll_i,
  input  logic        spr_5th_i,
  input  logic        irq_i,
  input  logic [4:0]  spr_5th_num_i,
  output opmode_t     opmode_o,
  output logic        reg_16k_o,
  output logic        reg_blank_o,
  output logic [3:0]  reg_ntb_o,
  output logic [3:0]  reg_col1_o,
  output logic [3:0]  reg_col0_o,
  output logic        int_n_o
);

  logic              sel_readahead;
  logic [DATA_W-1:0] tmp;
  logic [DATA_W-1:0] status;
  logic [DATA_W-1:0] buffer;

  vdp_cpu_cmd_if cmd_if ();

  vdp_access_fsm access_fsm_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .rd_i            (rd_i),
    .wr_i            (wr_i),
    .mode_i          (mode_i),
    .cd_i            (cd_i),
    .cmd             (cmd_if.fsm),
    .sel_readahead_o (sel_readahead)
  );

  vdp_vram_port vram_port_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd           (cmd_if.vram),
    .tmp_i         (tmp),
    .acc_slot_i    (acc_slot_i),
    .access_type_i (access_type_i),
    .vram_d_i      (vram_d_i),
    .vram_a_o      (vram_a_o),
    .vram_d_o      (vram_d_o),
    .vram_we_o     (vram_we_o),
    .buffer_o      (buffer)
  );

  vdp_reg_status reg_status_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd           (cmd_if.regs),
    .spr_coll_i    (spr_coll_i),
    .spr_5th_i     (spr_5th_i),
    .irq_i         (irq_i),
    .spr_5th_num_i (spr_5th_num_i),
    .tmp_o         (tmp),
    .status_o      (status),
    .opmode_o      (opmode_o),
    .reg_16k_o     (reg_16k_o),
    .reg_blank_o   (reg_blank_o),
    .reg_ntb_o     (reg_ntb_o),
    .reg_col1_o    (reg_col1_o),
    .reg_col0_o    (reg_col0_o),
    .int_n_o       (int_n_o)
  );

  // Read-ahead buffer during mode 0 reads, status otherwise
  assign cd_o = sel_readahead ? buffer : status;

endmodule

// File: test/vdp_cpuio_assert.sv
//--------------------------------------------------------------------
// Bound assertions on the CPU port top level
// VRAM strobe in CPU slots, single host strobe, interrupt masking
//--------------------------------------------------------------------

`timescale 1ns/1ps

module vdp_cpuio_assert
  import vdp_bus_pkg::*;
(
  input logic    clk_i,
  input logic    reset_i,
  input logic    rd_i,
  input logic    wr_i,
  input logic    vram_we_i,
  input access_t access_type_i,
  input logic    ie_i,
  input logic    int_n_i
);

  // VRAM writes only while the CPU owns the slot
  we_in_cpu_slot: assert property (@(posedge clk_i) disable iff (reset_i)
    vram_we_i |-> (access_type_i == AC_CPU))
    else $error("vram_we_o high outside a CPU access slot");

  // Host never strobes read and write together
  single_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    !(rd_i && wr_i))
    else $error("rd_i and wr_i high together");

  // No interrupt with IE clear
  int_masked: assert property (@(posedge clk_i) disable iff (reset_i)
    !ie_i |-> int_n_i)
    else $error("int_n_o low while IE is clear");

endmodule

bind vdp_cpuio vdp_cpuio_assert vdp_cpuio_assert_i (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .rd_i          (rd_i),
  .wr_i          (wr_i),
  .vram_we_i     (vram_we_o),
  .access_type_i (access_type_i),
  .ie_i          (reg_status_i.ctrl_q[vdp_reg_pkg::REG_MODE1][vdp_reg_pkg::R1_IE]),
  .int_n_i       (int_n_o)
);

// File: test/tb_vdp_cpuio.sv
//--------------------------------------------------------------------
// Testbench for the VDP CPU port
// Clock, reset, access slots, LFSR stimulus, VRAM and register model,
// typed compare tasks and the per-test report
//--------------------------------------------------------------------

`timescale 1ns/1ps

module tb_vdp_cpuio
  import vdp_bus_pkg::*;
  import vdp_reg_pkg::*;
();

  localparam int          N_XFER   = 8;
  localparam int          WAIT_MAX = 64;
  localparam logic [31:0] SEED     = 32'he167_160c;

  // DUT connections
  logic        clk;
  logic        reset;
  logic        rd;
  logic        wr;
  logic        mode;
  logic [7:0]  cd_in;
  logic [7:0]  cd_out;
  access_t     access_type;
  logic        acc_slot;
  logic [7:0]  vram_din;
  logic [13:0] vram_addr;
  logic [7:0]  vram_dout;
  logic        vram_we;
  logic        spr_coll;
  logic        spr_5th;
  logic        irq;
  logic [4:0]  spr_5th_num;
  opmode_t     opmode;
  logic        reg_16k;
  logic        reg_blank;
  logic [3:0]  reg_ntb;
  logic [3:0]  reg_col1;
  logic [3:0]  reg_col0;
  logic        int_n;

  // Model state
  logic [7:0]  vram_mem [1 << ADDR_W];
  logic [7:0]  reg_model [NUM_REGS];
  logic [13:0] addr_model;
  logic        coll_model;
  logic        fifth_model;
  logic        int_model;
  logic [4:0]  num_model;
  logic [31:0] lfsr;

  // Last write-back seen on the VRAM bus
  int          wb_count;
  logic [13:0] wb_addr;
  logic [7:0]  wb_data;

  int          tests;
  int          checks;
  int          test_errors;
  int          total_checks;
  int          total_errors;

  vdp_cpuio vdp_cpuio_i (
    .clk_i         (clk),
    .reset_i       (reset),
    .rd_i          (rd),
    .wr_i          (wr),
    .mode_i        (mode),
    .cd_i          (cd_in),
    .cd_o          (cd_out),
    .access_type_i (access_type),
    .acc_slot_i    (acc_slot),
    .vram_d_i      (vram_din),
    .vram_a_o      (vram_addr),
    .vram_d_o      (vram_dout),
    .vram_we_o     (vram_we),
    .spr_coll_i    (spr_coll),
    .spr_5th_i     (spr_5th),
    .irq_i         (irq),
    .spr_5th_num_i (spr_5th_num),
    .opmode_o      (opmode),
    .reg_16k_o     (reg_16k),
    .reg_blank_o   (reg_blank),
    .reg_ntb_o     (reg_ntb),
    .reg_col1_o    (reg_col1),
    .reg_col0_o    (reg_col0),
    .int_n_o       (int_n)
  );

  // 20 ns clock
  always
  begin
    clk = 1'b0;
    #10;
    clk = 1'b1;
    #10;
  end

  //--------------------------------------------------------------------
  // Video side slots every 4th cycle with every second slot for the CPU
  //--------------------------------------------------------------------
  initial
  begin
    int unsigned cyc;
    logic        cpu_turn;
    cyc         = 0;
    cpu_turn    = 1'b0;
    acc_slot    = 1'b0;
    access_type = AC_NONE;
    forever
    begin
      @(posedge clk);
      #2;
      cyc++;
      acc_slot = (cyc % 4 == 0);
      if (acc_slot)
      begin
        cpu_turn    = !cpu_turn;
        access_type = cpu_turn ? AC_CPU : AC_PATTERN;
      end
    end
  end

  // VRAM filled from the whole address and written on slot-aligned strobes
  initial
  begin
    int a;
    for (a = 0; a < (1 << ADDR_W); a++)
      vram_mem[a] = 8'(a) ^ 8'(a >> 6) ^ 8'h3c;
    wb_count = 0;
    wb_addr  = '0;
    wb_data  = '0;
    forever
    begin
      @(negedge clk);
      if (!reset && vram_we && acc_slot)
      begin
        vram_mem[vram_addr] = vram_dout;
        wb_addr             = vram_addr;
        wb_data             = vram_dout;
        wb_count++;
      end
    end
  end

  assign vram_din = vram_mem[vram_addr];

  //--------------------------------------------------------------------
  // Random source
  //--------------------------------------------------------------------
  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h8020_0003;
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  //--------------------------------------------------------------------
  // Reference rules
  //--------------------------------------------------------------------
  // M1 text, M2 multicolour, M3 graphics II, none graphics I, mixes text
  function automatic opmode_t mode_rule(input logic m1, input logic m2, input logic m3);
    if (!m1 && !m2 && !m3)
      return OPMODE_GRAPH1;
    else if (!m1 && !m2 && m3)
      return OPMODE_GRAPH2;
    else if (!m1 && m2 && !m3)
      return OPMODE_MULTIC;
    return OPMODE_TEXTM;
  endfunction

  function automatic logic [7:0] status_model();
    return {int_model, fifth_model, coll_model, num_model};
  endfunction

  //--------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------
  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("[ERROR] t=%0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [13:0] got,
                            input logic [13:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("[ERROR] t=%0t %s got 0x%04h expected 0x%04h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_mode(input string name, input opmode_t got, input opmode_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("[ERROR] t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      test_errors++;
    end
  endtask

  // Decoded register fields against the register model
  task automatic check_fields();
    check_mode("opmode_o", opmode, mode_rule(reg_model[REG_MODE1][R1_M1],
               reg_model[REG_MODE1][R1_M2], reg_model[REG_MODE0][R0_M3]));
    check_byte("reg_blank_o", {7'd0, reg_blank}, {7'd0, !reg_model[REG_MODE1][R1_BLANK]});
    check_byte("reg_16k_o", {7'd0, reg_16k}, {7'd0, reg_model[REG_MODE1][R1_16K]});
    check_byte("reg_ntb_o", {4'd0, reg_ntb}, {4'd0, reg_model[REG_NTB][3:0]});
    check_byte("reg_col1_o", {4'd0, reg_col1}, {4'd0, reg_model[REG_COLOR][7:4]});
    check_byte("reg_col0_o", {4'd0, reg_col0}, {4'd0, reg_model[REG_COLOR][3:0]});
  endtask

  task automatic check_int_n();
    check_byte("int_n_o", {7'd0, int_n},
               {7'd0, !(int_model && reg_model[REG_MODE1][R1_IE])});
  endtask

  task automatic finish_test(input string name);
    $display("Test %s: %0d checks, %0d errors", name, checks, test_errors);
    tests++;
    total_checks += checks;
    total_errors += test_errors;
    checks      = 0;
    test_errors = 0;
  endtask

  //--------------------------------------------------------------------
  // Host bus
  //--------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // Two-cycle strobe with read data taken mid-access and then the idle gap
  task automatic host_access(input logic is_rd, input logic sel, input logic [7:0] data,
                             output logic [7:0] rdata);
    mode  = sel;
    cd_in = data;
    rd    = is_rd;
    wr    = !is_rd;
    @(posedge clk);
    @(negedge clk);
    rdata = cd_out;
    next_cycle();
    // Data byte stays put since the end-of-access command still uses it
    rd = 1'b0;
    wr = 1'b0;
    repeat (16) next_cycle();
  endtask

  task automatic host_write(input logic sel, input logic [7:0] data);
    logic [7:0] ignored;
    host_access(1'b0, sel, data, ignored);
  endtask

  task automatic host_read(input logic sel, output logic [7:0] data);
    host_access(1'b1, sel, 8'h00, data);
  endtask

  task automatic control_pair(input logic [7:0] first, input logic [7:0] second);
    host_write(1'b1, first);
    host_write(1'b1, second);
  endtask

  //--------------------------------------------------------------------
  // Bounded waits
  //--------------------------------------------------------------------
  task automatic wait_writeback(input int prev);
    int n;
    n = 0;
    while (wb_count == prev && n < WAIT_MAX)
    begin
      next_cycle();
      n++;
    end
    if (wb_count == prev)
    begin
      $display("No VRAM write-back seen within %0d cycles at t=%0t", WAIT_MAX, $time);
      test_errors++;
    end
  endtask

  // Address moves past the byte once its read-ahead is done
  task automatic wait_address(input logic [13:0] addr);
    int n;
    n = 0;
    while (vram_addr !== addr && n < WAIT_MAX)
    begin
      next_cycle();
      n++;
    end
    if (vram_addr !== addr)
    begin
      $display("VRAM address never reached 0x%04h, read-ahead did not finish", addr);
      test_errors++;
    end
  endtask

  task automatic wait_int_low();
    int n;
    n = 0;
    while (int_n !== 1'b0 && n < WAIT_MAX)
    begin
      next_cycle();
      n++;
    end
    if (int_n !== 1'b0)
    begin
      $display("Interrupt output stayed high for %0d cycles at t=%0t", WAIT_MAX, $time);
      test_errors++;
    end
  endtask

  //--------------------------------------------------------------------
  // Side-band events
  //--------------------------------------------------------------------
  task automatic sprite_events();
    logic [31:0] r;
    r           = rand_bits(7);
    spr_coll    = r[0];
    spr_5th     = r[1];
    spr_5th_num = r[6:2];
    if (spr_coll)
      coll_model = 1'b1;
    // Number sticks from the first event after a clear
    if (spr_5th && !fifth_model)
      num_model = spr_5th_num;
    if (spr_5th)
      fifth_model = 1'b1;
    next_cycle();
    spr_coll = 1'b0;
    spr_5th  = 1'b0;
    next_cycle();
  endtask

  task automatic pulse_irq();
    irq = 1'b1;
    next_cycle();
    irq       = 1'b0;
    int_model = 1'b1;
  endtask

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------
  initial
  begin
    logic [7:0]  data;
    logic [7:0]  got;
    logic [13:0] base;
    logic [31:0] r;
    int          prev;
    int          i;
    int          k;
    int          round;

    lfsr         = SEED;
    reset        = 1'b1;
    rd           = 1'b0;
    wr           = 1'b0;
    mode         = 1'b0;
    cd_in        = 8'h00;
    spr_coll     = 1'b0;
    spr_5th      = 1'b0;
    irq          = 1'b0;
    spr_5th_num  = 5'd0;
    tests        = 0;
    checks       = 0;
    test_errors  = 0;
    total_checks = 0;
    total_errors = 0;
    addr_model   = '0;
    coll_model   = 1'b0;
    fifth_model  = 1'b0;
    int_model    = 1'b0;
    num_model    = '0;
    for (i = 0; i < NUM_REGS; i++)
      reg_model[i] = 8'h00;

    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    next_cycle();

    // Reset values
    check_byte("vram_we_o", {7'd0, vram_we}, 8'h00);
    check_byte("int_n_o", {7'd0, int_n}, 8'h01);
    check_addr("vram_a_o", vram_addr, 14'h0000);
    check_byte("cd_o", cd_out, 8'h00);
    check_fields();
    finish_test("reset");

    // Write-back at consecutive addresses
    base = 14'(rand_bits(14));
    control_pair(base[7:0], {SECOND_BYTE_WR, base[13:8]});
    addr_model = base;
    check_addr("vram_a_o", vram_addr, addr_model);
    for (i = 0; i < N_XFER; i++)
    begin
      data = 8'(rand_bits(8));
      prev = wb_count;
      host_write(1'b0, data);
      wait_writeback(prev);
      check_addr("vram_a_o", wb_addr, addr_model);
      check_byte("vram_d_o", wb_data, data);
      addr_model = addr_model + 14'd1;
    end
    check_addr("vram_a_o", vram_addr, addr_model);
    finish_test("write-back");

    // Read-ahead where each read returns the byte fetched before it
    base = 14'(rand_bits(14));
    control_pair(base[7:0], {SECOND_BYTE_RD, base[13:8]});
    addr_model = base;
    for (i = 0; i < N_XFER; i++)
    begin
      wait_address(addr_model + 14'd1);
      host_read(1'b0, got);
      check_byte("cd_o", got, vram_mem[addr_model]);
      addr_model = addr_model + 14'd1;
    end
    finish_test("read-ahead");

    // Control registers in two passes over all eight
    for (round = 0; round < 2; round++)
    begin
      for (k = 0; k < NUM_REGS; k++)
      begin
        data = 8'(rand_bits(8));
        r    = rand_bits(4);
        control_pair(data, {1'b1, r[3:0], k[2:0]});
        reg_model[k] = data;
        check_fields();
      end
    end
    finish_test("registers");

    // Sticky sprite flags cleared by the status read
    host_read(1'b1, got);
    for (round = 0; round < 3; round++)
    begin
      for (k = 0; k < 4; k++)
        sprite_events();
      host_read(1'b1, got);
      check_byte("cd_o", got, status_model());
      coll_model  = 1'b0;
      fifth_model = 1'b0;
      host_read(1'b1, got);
      check_byte("cd_o", got, status_model());
    end
    finish_test("status");

    // Interrupt masked by IE
    reg_model[REG_MODE1][R1_IE] = 1'b0;
    control_pair(reg_model[REG_MODE1], 8'h81);
    pulse_irq();
    for (k = 0; k < 4; k++)
    begin
      check_int_n();
      next_cycle();
    end
    host_read(1'b1, got);
    check_byte("cd_o", got, status_model());
    int_model = 1'b0;
    reg_model[REG_MODE1][R1_IE] = 1'b1;
    control_pair(reg_model[REG_MODE1], 8'h81);
    check_int_n();
    pulse_irq();
    wait_int_low();
    check_int_n();
    host_read(1'b1, got);
    check_byte("cd_o", got, status_model());
    int_model = 1'b0;
    check_int_n();
    check_fields();
    finish_test("interrupt");

    $display("Tests %0d, checks %0d, errors %0d", tests, total_checks, total_errors);
    if (total_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: compile.f
hw/vdp_bus_pkg.sv
hw/vdp_reg_pkg.sv
hw/vdp_cpu_cmd_if.sv
hw/vdp_access_fsm.sv
hw/vdp_vram_port.sv
hw/vdp_reg_status.sv
hw/vdp_cpuio.sv
test/vdp_cpuio_assert.sv
test/tb_vdp_cpuio.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the VDP CPU port testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_vdp_cpuio --Mdir "$BUILD" -o tb_vdp_cpuio
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD/tb_vdp_cpuio" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0
